// File: source/ppu_pkg.sv
package ppu_pkg;

    // frame geometry
    localparam int dots_per_line = 341;
    localparam int lines_per_frame = 262;
    localparam int screen_width = 256;

    // vertical landmarks
    localparam int first_visible_row = 1;
    localparam int last_visible_row = 240;
    localparam int post_render_row = 241;

    // horizontal landmarks at the last col of each fetch phase
    localparam int idle_dot = 256;
    localparam int sprite_fetch_end = 320;
    localparam int tile_fetch_end = 336;

    localparam int left_clip_width = 8;
    localparam int nmi_dots = 3;
    localparam int pal_entries = 32;

    typedef logic [8:0] row_t;
    typedef logic [8:0] col_t;
    typedef logic [5:0] color_t;
    typedef logic [4:0] pal_addr_t;

    // keeps only the luma column of the palette
    localparam color_t greyscale_mask = 6'h30;

    typedef struct packed {
        row_t row;
        col_t col;
    } scan_pos_t;

    typedef struct packed {
        logic [3:0] bg_color_idx;
        logic [3:0] sp_color_idx;
        // 1 puts the background in front
        logic sp_prio;
        logic sp_zero;
    } pixel_in_t;

    typedef enum logic [2:0] {
        reg_ctrl = 3'd0,
        reg_mask = 3'd1,
        reg_status = 3'd2,
        reg_pal_addr = 3'd3,
        reg_pal_data = 3'd4
    } reg_sel_t;

    typedef struct packed {
        logic nmi_enable;
        logic [6:0] reserved;
    } ctrl_bits_t;

    typedef struct packed {
        logic [2:0] reserved;
        logic sp_enable;
        logic bg_enable;
        logic sp_left;
        logic bg_left;
        logic greyscale;
    } mask_bits_t;

    // cpu write word decoded as ctrl or mask by the target register
    typedef union packed {
        ctrl_bits_t ctrl;
        mask_bits_t mask;
        logic [7:0] raw;
    } reg_word_u;

    typedef enum logic [2:0] {
        sl_pre_cyc,
        idle_cyc,
        sp_pre_cyc,
        tl_pre_cyc,
        garb_cyc
    } hs_state_t;

    typedef enum logic [1:0] {
        pre_sl,
        vis_sl,
        post_sl,
        vblank_sl
    } vs_state_t;

endpackage

// File: source/dot_counter.sv
`timescale 1ns/10ps

module dot_counter
    import ppu_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic dot_en,
    output scan_pos_t pos,
    output logic line_end,
    output logic frame_end
);

    // last dot of a line, and last dot of the last line
    assign line_end = (pos.col == col_t'(dots_per_line - 1));
    assign frame_end = line_end && (pos.row == row_t'(lines_per_frame - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (dot_en) begin
            if (line_end) begin
                pos.col <= '0;
                if (frame_end) begin
                    pos.row <= '0;
                end else begin
                    pos.row <= pos.row + 1'b1;
                end
            end else begin
                pos.col <= pos.col + 1'b1;
            end
        end
    end

    // counter must stay inside the 341 x 262 raster
    a_pos_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pos.col < col_t'(dots_per_line)) && (pos.row < row_t'(lines_per_frame))
    );

endmodule

// File: source/scan_fsm.sv
`timescale 1ns/10ps

module scan_fsm
    import ppu_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic dot_en,
    input scan_pos_t pos,
    input logic line_end,
    input logic frame_end,
    input logic nmi_enable,
    output logic render_active,
    output logic status_clr,
    output logic vblank_set,
    output logic vblank_nmi
);

    hs_state_t hs_state, hs_next;
    vs_state_t vs_state, vs_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= sl_pre_cyc;
            vs_state <= pre_sl;
        end else if (dot_en) begin
            hs_state <= hs_next;
            vs_state <= vs_next;
        end
    end

    // each phase ends on its last col, the next one starts a dot later
    always_comb begin
        hs_next = hs_state;
        case (hs_state)
            sl_pre_cyc: if (pos.col == col_t'(idle_dot - 1)) hs_next = idle_cyc;
            idle_cyc: hs_next = sp_pre_cyc;
            sp_pre_cyc: if (pos.col == col_t'(sprite_fetch_end)) hs_next = tl_pre_cyc;
            tl_pre_cyc: if (pos.col == col_t'(tile_fetch_end)) hs_next = garb_cyc;
            garb_cyc: if (line_end) hs_next = sl_pre_cyc;
            default: hs_next = sl_pre_cyc;
        endcase
    end

    always_comb begin
        vs_next = vs_state;
        case (vs_state)
            pre_sl: if (line_end && pos.row == row_t'(first_visible_row - 1)) vs_next = vis_sl;
            vis_sl: if (line_end && pos.row == row_t'(last_visible_row)) vs_next = post_sl;
            post_sl: if (line_end && pos.row == row_t'(post_render_row)) vs_next = vblank_sl;
            vblank_sl: if (frame_end) vs_next = pre_sl;
            default: vs_next = pre_sl;
        endcase
    end

    assign render_active = (hs_state == sl_pre_cyc) && (vs_state == vis_sl);
    assign status_clr = (vs_state == pre_sl) && (pos.col == '0);
    assign vblank_set = (vs_state == post_sl) && (pos.col == '0);
    // nmi is active low for the first few dots of the post-render line
    assign vblank_nmi = !((vs_state == post_sl) && (pos.col < col_t'(nmi_dots)) && nmi_enable);

    a_hs_visible: assert property (@(posedge clk) disable iff (!rst_n)
        (hs_state == sl_pre_cyc) == (pos.col < col_t'(idle_dot)));
    a_hs_garbage: assert property (@(posedge clk) disable iff (!rst_n)
        (hs_state == garb_cyc) == (pos.col > col_t'(tile_fetch_end)));
    a_no_render_pre: assert property (@(posedge clk) disable iff (!rst_n)
        render_active |-> (pos.row >= row_t'(first_visible_row)));

endmodule

// File: source/ppu_regs.sv
`timescale 1ns/10ps

module ppu_regs
    import ppu_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic dot_en,
    input logic reg_en,
    input logic reg_rw,
    input reg_sel_t reg_sel,
    input logic [7:0] reg_data_in,
    output logic [7:0] reg_data_out,
    input logic status_clr,
    input logic vblank_set,
    input logic sp_zero_set,
    output logic nmi_enable,
    output mask_bits_t mask,
    output logic pal_wr,
    output pal_addr_t pal_wr_addr,
    output color_t pal_wr_data
);

    reg_word_u wr_word;
    logic wr_en;
    logic pal_data_wr;
    logic status_rd;
    logic vblank;
    logic sp_zero_hit;
    pal_addr_t pal_ptr;

    assign wr_word = reg_data_in;
    assign wr_en = dot_en && reg_en && reg_rw;
    assign pal_data_wr = wr_en && (reg_sel == reg_pal_data);
    assign status_rd = dot_en && reg_en && !reg_rw && (reg_sel == reg_status);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nmi_enable <= 1'b0;
            mask <= '0;
            pal_ptr <= '0;
            pal_wr <= 1'b0;
            vblank <= 1'b0;
            sp_zero_hit <= 1'b0;
        end else if (dot_en) begin
            pal_wr <= pal_data_wr;
            if (wr_en && reg_sel == reg_ctrl) nmi_enable <= wr_word.ctrl.nmi_enable;
            if (wr_en && reg_sel == reg_mask) mask <= wr_word.mask;
            // pointer auto-increments after each data write and wraps at 32
            if (wr_en && reg_sel == reg_pal_addr) begin
                pal_ptr <= reg_data_in[4:0];
            end else if (pal_data_wr) begin
                pal_ptr <= pal_ptr + 1'b1;
            end
            // set strobes take priority over clears
            if (vblank_set) vblank <= 1'b1;
            else if (status_clr || status_rd) vblank <= 1'b0;
            if (sp_zero_set) sp_zero_hit <= 1'b1;
            else if (status_clr) sp_zero_hit <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dot_en && pal_data_wr) begin
            pal_wr_addr <= pal_ptr;
            pal_wr_data <= reg_data_in[5:0];
        end
    end

    // bit 5 is the unmodelled overflow flag and reads 0
    assign reg_data_out = (reg_sel == reg_status) ? {vblank, sp_zero_hit, 6'b0} : 8'h00;

    a_pal_wr_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pal_wr) |-> $past(dot_en && reg_en && reg_rw && (reg_sel == reg_pal_data)));

endmodule

// File: source/pixel_mux.sv
`timescale 1ns/10ps

module pixel_mux
    import ppu_pkg::*;
(
    input pixel_in_t in_px,
    input col_t col,
    input mask_bits_t mask,
    input logic render_active,
    output pal_addr_t pal_rd_addr,
    output logic sp_zero_set
);

    logic in_left_band;
    logic bg_shown;
    logic sp_shown;
    logic [3:0] bg_idx;
    logic [3:0] sp_idx;
    logic bg_opaque;
    logic sp_opaque;

    assign in_left_band = (col < col_t'(left_clip_width));

    // a layer is hidden when disabled or clipped in the left band
    assign bg_shown = mask.bg_enable && !(in_left_band && !mask.bg_left);
    assign sp_shown = mask.sp_enable && !(in_left_band && !mask.sp_left);

    assign bg_idx = bg_shown ? in_px.bg_color_idx : 4'h0;
    assign sp_idx = sp_shown ? in_px.sp_color_idx : 4'h0;

    // colour 0 of any sub-palette is transparent
    assign bg_opaque = (bg_idx[1:0] != 2'b00);
    assign sp_opaque = (sp_idx[1:0] != 2'b00);

    always_comb begin
        pal_rd_addr = {1'b0, bg_idx};
        if (sp_opaque && !bg_opaque) begin
            pal_rd_addr = {1'b1, sp_idx};
        end else if (sp_opaque && bg_opaque && !in_px.sp_prio) begin
            // sprite in front of the background
            pal_rd_addr = {1'b1, sp_idx};
        end
    end

    // no hit on the rightmost dot
    assign sp_zero_set = render_active
                      && (col < col_t'(screen_width - 1))
                      && in_px.sp_zero
                      && bg_opaque
                      && sp_opaque;

endmodule

// File: source/palette_ram.sv
`timescale 1ns/10ps

module palette_ram
    import ppu_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic dot_en,
    input logic pal_wr,
    input pal_addr_t pal_wr_addr,
    input color_t pal_wr_data,
    input pal_addr_t pal_rd_addr,
    input logic greyscale,
    input logic render_active,
    output color_t pixel_color,
    output logic pixel_valid
);

    color_t pal_mem [pal_entries];
    color_t rd_color;
    color_t out_color;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pal_entries; i++) begin
                pal_mem[i] <= '0;
            end
        end else if (dot_en && pal_wr) begin
            pal_mem[pal_wr_addr] <= pal_wr_data;
        end
    end

    // async read at the merged render address
    assign rd_color = pal_mem[pal_rd_addr];
    assign out_color = greyscale ? (rd_color & greyscale_mask) : rd_color;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
        end else if (dot_en) begin
            pixel_valid <= render_active;
        end
    end

    always_ff @(posedge clk) begin
        if (dot_en) pixel_color <= out_color;
    end

endmodule

// File: source/ppu_core.sv
`timescale 1ns/10ps

module ppu_core
    import ppu_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic dot_en,
    input logic reg_en,
    input logic reg_rw,
    input reg_sel_t reg_sel,
    input logic [7:0] reg_data_in,
    output logic [7:0] reg_data_out,
    input pixel_in_t in_px,
    output color_t pixel_color,
    output logic pixel_valid,
    output logic vblank_nmi
);

    scan_pos_t pos;
    logic line_end, frame_end;
    logic render_active, status_clr, vblank_set, sp_zero_set;
    logic nmi_enable;
    mask_bits_t mask;
    logic pal_wr;
    pal_addr_t pal_wr_addr, pal_rd_addr;
    color_t pal_wr_data;

    dot_counter dot_counter_inst (.clk, .rst_n, .dot_en, .pos, .line_end, .frame_end);

    scan_fsm scan_fsm_inst (
        .clk, .rst_n, .dot_en, .pos, .line_end, .frame_end, .nmi_enable,
        .render_active, .status_clr, .vblank_set, .vblank_nmi
    );

    ppu_regs ppu_regs_inst (
        .clk, .rst_n, .dot_en, .reg_en, .reg_rw, .reg_sel, .reg_data_in, .reg_data_out,
        .status_clr, .vblank_set, .sp_zero_set, .nmi_enable, .mask,
        .pal_wr, .pal_wr_addr, .pal_wr_data
    );

    pixel_mux pixel_mux_inst (
        .in_px, .col(pos.col), .mask, .render_active, .pal_rd_addr, .sp_zero_set
    );

    palette_ram palette_ram_inst (
        .clk, .rst_n, .dot_en, .pal_wr, .pal_wr_addr, .pal_wr_data, .pal_rd_addr,
        .greyscale(mask.greyscale), .render_active, .pixel_color, .pixel_valid
    );

endmodule

// File: tests/ppu_core_tb.sv
`timescale 1ns/10ps

module ppu_core_tb
    import ppu_pkg::*;
;

    typedef enum logic [1:0] {act_none, act_write, act_read} act_t;
    typedef enum logic [2:0] {chk_none, chk_color, chk_valid, chk_status, chk_nmi} chk_t;

    // table row with the target dot, cpu action, pixel and expected value
    typedef struct packed {
        row_t row;
        col_t col;
        act_t act;
        reg_sel_t sel;
        logic [7:0] data;
        pixel_in_t px;
        chk_t chk;
        logic [7:0] exp;
    } step_t;

    // two frames plus margin
    localparam int cycle_limit = 2 * dots_per_line * lines_per_frame + 1000;

    logic clk, rst_n, dot_en, reg_en, reg_rw, pixel_valid, vblank_nmi;
    reg_sel_t reg_sel;
    logic [7:0] reg_data_in, reg_data_out;
    pixel_in_t in_px;
    color_t pixel_color;

    step_t steps[$];
    color_t pal_model [pal_entries];
    mask_bits_t mask_model;
    logic [31:0] lfsr;
    int cur_row, cur_col, cycles, errors;
    logic [7:0] rd_now;
    logic nmi_now;

    ppu_core ppu_core_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_color(output color_t c);
        c = '0;
        for (int b = 0; b < 6; b++) begin
            lfsr = lfsr_step(lfsr);
            c = {c[4:0], lfsr[0]};
        end
    endtask

    // expected colour from the merge rules and the mirrored palette
    function automatic color_t expected_color(input pixel_in_t px, input int col);
        logic [3:0] bg;
        logic [3:0] sp;
        pal_addr_t addr;
        color_t c;
        bg = px.bg_color_idx;
        sp = px.sp_color_idx;
        if (!mask_model.bg_enable || (col < left_clip_width && !mask_model.bg_left)) bg = 4'h0;
        if (!mask_model.sp_enable || (col < left_clip_width && !mask_model.sp_left)) sp = 4'h0;
        if (sp[1:0] == 2'b00) addr = {1'b0, bg};
        else if (bg[1:0] == 2'b00) addr = {1'b1, sp};
        else addr = px.sp_prio ? {1'b0, bg} : {1'b1, sp};
        c = pal_model[addr];
        if (mask_model.greyscale) c = c & 6'h30;
        return c;
    endfunction

    task automatic add_step(input int row, input int col, input act_t act, input reg_sel_t sel,
                            input logic [7:0] data, input logic [3:0] bg, input logic [3:0] sp,
                            input logic prio, input logic zero, input chk_t chk,
                            input logic [7:0] exp);
        step_t e;
        e.row = row_t'(row);
        e.col = col_t'(col);
        e.act = act;
        e.sel = sel;
        e.data = data;
        e.px = {bg, sp, prio, zero};
        e.chk = chk;
        e.exp = exp;
        steps.push_back(e);
    endtask

    // drive at the falling edge, sample mid low phase, return at the next falling edge
    task automatic drive_dot(input logic en, input logic rw, input reg_sel_t sel,
                             input logic [7:0] data, input pixel_in_t px);
        reg_en = en;
        reg_rw = rw;
        reg_sel = sel;
        reg_data_in = data;
        in_px = px;
        #10;
        rd_now = reg_data_out;
        nmi_now = vblank_nmi;
        @(posedge clk);
        if (cur_col == dots_per_line - 1) begin
            cur_col = 0;
            cur_row = (cur_row == lines_per_frame - 1) ? 0 : cur_row + 1;
        end else begin
            cur_col++;
        end
        @(negedge clk);
    endtask

    task automatic goto_dot(input int row, input int col);
        while (!(cur_row == row && cur_col == col)) begin
            drive_dot(1'b0, 1'b0, reg_ctrl, 8'h00, '0);
        end
    endtask

    task automatic fill_palette();
        color_t c;
        drive_dot(1'b1, 1'b1, reg_ctrl, 8'h80, '0);
        drive_dot(1'b1, 1'b1, reg_mask, 8'h1e, '0);
        mask_model = 8'h1e;
        drive_dot(1'b1, 1'b1, reg_pal_addr, 8'h00, '0);
        for (int i = 0; i < pal_entries; i++) begin
            draw_color(c);
            pal_model[i] = c;
            drive_dot(1'b1, 1'b1, reg_pal_data, {2'b00, c}, '0);
        end
    endtask

    task automatic run_step(input step_t s);
        color_t want;
        want = expected_color(s.px, int'(s.col));
        drive_dot(s.act != act_none, s.act == act_write, s.sel, s.data, s.px);
        if (s.act == act_write && s.sel == reg_mask) mask_model = s.data;
        case (s.chk)
            chk_color: assert (pixel_valid === 1'b1 && pixel_color === want) else begin
                errors++;
                $display("MISMATCH %0t: dot %0d,%0d colour %h valid %b, expected %h",
                         $time, s.row, s.col, pixel_color, pixel_valid, want);
            end
            chk_valid: assert (pixel_valid === s.exp[0]) else begin
                errors++;
                $display("MISMATCH %0t: dot %0d,%0d valid %b, expected %b",
                         $time, s.row, s.col, pixel_valid, s.exp[0]);
            end
            chk_status: assert (rd_now === s.exp) else begin
                errors++;
                $display("MISMATCH %0t: dot %0d,%0d status %h, expected %h",
                         $time, s.row, s.col, rd_now, s.exp);
            end
            chk_nmi: assert (nmi_now === s.exp[0]) else begin
                errors++;
                $display("MISMATCH %0t: dot %0d,%0d nmi %b, expected %b",
                         $time, s.row, s.col, nmi_now, s.exp[0]);
            end
            default: ;
        endcase
    endtask

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        dot_en = 1'b1;
        reg_en = 1'b0;
        reg_rw = 1'b0;
        reg_sel = reg_ctrl;
        reg_data_in = 8'h00;
        in_px = '0;
        mask_model = '0;
        lfsr = 32'hf070;
        cur_row = 0;
        cur_col = 0;
        cycles = 0;
        errors = 0;

        // frame 0 covers window, merge and mask, then vblank and nmi
        add_step(0, 100, act_none, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_valid, 8'h00);
        add_step(1, 0, act_none, reg_ctrl, 8'h00, 4'h1, 4'h2, 1'b0, 1'b0, chk_color, 8'h00);
        add_step(1, 1, act_none, reg_ctrl, 8'h00, 4'h5, 4'h6, 1'b1, 1'b0, chk_color, 8'h00);
        add_step(1, 2, act_none, reg_ctrl, 8'h00, 4'h4, 4'h7, 1'b1, 1'b0, chk_color, 8'h00);
        add_step(1, 3, act_none, reg_ctrl, 8'h00, 4'hb, 4'h8, 1'b0, 1'b0, chk_color, 8'h00);
        add_step(1, 4, act_none, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_color, 8'h00);
        add_step(1, 255, act_none, reg_ctrl, 8'h00, 4'h3, 4'hd, 1'b0, 1'b1, chk_color, 8'h00);
        add_step(1, 300, act_none, reg_ctrl, 8'h00, 4'h3, 4'h3, 1'b0, 1'b0, chk_valid, 8'h00);
        add_step(2, 10, act_write, reg_mask, 8'h16, 4'h0, 4'h0, 1'b0, 1'b0, chk_none, 8'h00);
        add_step(2, 20, act_none, reg_ctrl, 8'h00, 4'h3, 4'h6, 1'b1, 1'b0, chk_color, 8'h00);
        add_step(2, 21, act_none, reg_ctrl, 8'h00, 4'h3, 4'h0, 1'b0, 1'b0, chk_color, 8'h00);
        add_step(3, 0, act_write, reg_mask, 8'h1a, 4'h0, 4'h0, 1'b0, 1'b0, chk_none, 8'h00);
        add_step(3, 5, act_none, reg_ctrl, 8'h00, 4'h2, 4'h3, 1'b0, 1'b0, chk_color, 8'h00);
        add_step(3, 8, act_none, reg_ctrl, 8'h00, 4'h2, 4'h3, 1'b0, 1'b0, chk_color, 8'h00);
        add_step(4, 0, act_write, reg_mask, 8'h1f, 4'h0, 4'h0, 1'b0, 1'b0, chk_none, 8'h00);
        add_step(4, 50, act_none, reg_ctrl, 8'h00, 4'h1, 4'ha, 1'b0, 1'b0, chk_color, 8'h00);
        add_step(5, 0, act_write, reg_mask, 8'h1e, 4'h0, 4'h0, 1'b0, 1'b0, chk_none, 8'h00);
        // no hit yet, overlaps so far had sp_zero clear or sat on col 255
        add_step(5, 10, act_read, reg_status, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_status, 8'h00);
        add_step(6, 40, act_none, reg_ctrl, 8'h00, 4'h2, 4'h1, 1'b1, 1'b1, chk_color, 8'h00);
        add_step(240, 255, act_none, reg_ctrl, 8'h00, 4'h7, 4'h0, 1'b0, 1'b0, chk_color, 8'h00);
        add_step(240, 340, act_none, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_nmi, 8'h01);
        add_step(241, 0, act_none, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_nmi, 8'h00);
        add_step(241, 1, act_none, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_nmi, 8'h00);
        add_step(241, 2, act_none, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_nmi, 8'h00);
        add_step(241, 3, act_none, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_nmi, 8'h01);
        add_step(241, 5, act_none, reg_ctrl, 8'h00, 4'h3, 4'h3, 1'b0, 1'b0, chk_valid, 8'h00);
        add_step(241, 10, act_read, reg_status, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_status, 8'hc0);
        add_step(241, 11, act_read, reg_status, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_status, 8'h40);
        // frame 1 covers the sprite-zero clear and nmi disabled
        add_step(0, 0, act_read, reg_status, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_status, 8'h40);
        add_step(0, 5, act_read, reg_status, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_status, 8'h00);
        add_step(0, 10, act_write, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_none, 8'h00);
        add_step(241, 0, act_none, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_nmi, 8'h01);
        add_step(241, 2, act_none, reg_ctrl, 8'h00, 4'h0, 4'h0, 1'b0, 1'b0, chk_nmi, 8'h01);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fill_palette();
        foreach (steps[i]) begin
            goto_dot(int'(steps[i].row), int'(steps[i].col));
            run_step(steps[i]);
        end

        $display("table steps: %0d, errors: %0d", steps.size(), errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: project.f
source/ppu_pkg.sv
source/dot_counter.sv
source/scan_fsm.sv
source/ppu_regs.sv
source/pixel_mux.sv
source/palette_ram.sv
source/ppu_core.sv
tests/ppu_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --assert -j 0 --top-module ppu_core_tb -f project.f \
    -o ppu_core_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see $build_log"
    exit 1
fi

./obj_dir/ppu_core_sim > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $sim_log"
    exit 1
fi

if grep -qx "Done: no errors" "$sim_log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $sim_log"
exit 1
